/* verilog/fc_cfg.svh */
`ifndef FC_CFG_SVH
`define FC_CFG_SVH

// ====================
// Control loop
// ====================

// Gyro samples consumed per loop run
`define FC_GYRO_DIVIDE 4

// RC scaling, floor(v * MUL / 2^SHIFT) - OFFSET
`define FC_SP_SCALE_MUL 5
`define FC_SP_SCALE_SHIFT 3
`define FC_SP_OFFSET 620

// P gain as numerator and right shift
`define FC_P_GAIN 1
`define FC_P_SHIFT 0

`define FC_THROTTLE_OFFSET 1000
`define FC_MOTOR_MAX 2047

// ====================
// DShot timing, in clock cycles
// ====================
`define FC_DSHOT_BIT_TICKS 8
`define FC_DSHOT_ONE_HIGH 6
`define FC_DSHOT_ZERO_HIGH 3
`define FC_DSHOT_GAP_TICKS 16

`endif

/* verilog/fc_pkg.sv */
`default_nettype none

package fc_pkg;

  // Raw RC channel as delivered by the receiver
  typedef logic [10:0] rc_value_t;

  // Gyro rate straight from the IMU
  typedef logic signed [15:0] gyro_rate_t;

  // Setpoints, errors and loop terms
  typedef logic signed [31:0] axis_value_t;

  // DShot throttle command
  typedef logic [10:0] motor_cmd_t;

  // Command, telemetry bit, checksum
  typedef logic [15:0] dshot_frame_t;

  // Index into the setpoint array
  typedef enum logic [1:0] {
    THROTTLE = 2'd0,
    ROLL     = 2'd1,
    PITCH    = 2'd2,
    YAW      = 2'd3
  } axis_e;

  // Rate loop sequence
  typedef enum logic [2:0] {
    LOOP_WAIT  = 3'd0,
    LOOP_PID   = 3'd1,
    LOOP_MIX   = 3'd2,
    LOOP_CLAMP = 3'd3,
    LOOP_APPLY = 3'd4
  } loop_state_e;

endpackage

`default_nettype wire

/* verilog/fc_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Motor command set from the rate loop, valid only during the strobe
interface motor_cmd_if;
  logic                           cmd_valid;
  fc_pkg::motor_cmd_t [3:0]       cmd;

  modport producer (
    output cmd_valid,
    output cmd
  );

  modport buffer (
    input cmd_valid,
    input cmd
  );
endinterface

// Pending DShot frames, taken by the serializer when it goes idle
interface dshot_frame_if;
  logic                           frame_valid;
  fc_pkg::dshot_frame_t [3:0]     frames;
  logic                           frame_take;

  modport buffer (
    output frame_valid,
    output frames,
    input  frame_take
  );

  modport serializer (
    input  frame_valid,
    input  frames,
    output frame_take
  );
endinterface

`default_nettype wire

/* verilog/fc_rate_loop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module fc_rate_loop (
  input  logic               clk,
  input  logic               reset,
  input  logic               arm,
  input  logic               rc_valid,
  input  fc_pkg::rc_value_t  rc_throttle,
  input  fc_pkg::rc_value_t  rc_roll,
  input  fc_pkg::rc_value_t  rc_pitch,
  input  fc_pkg::rc_value_t  rc_yaw,
  input  logic               gyro_valid,
  input  fc_pkg::gyro_rate_t gyro_roll,
  input  fc_pkg::gyro_rate_t gyro_pitch,
  input  fc_pkg::gyro_rate_t gyro_yaw,
  motor_cmd_if.producer      cmd
);

  localparam int CNT_W = $clog2(`FC_GYRO_DIVIDE + 1);

  // Negative mix sign per motor, bit 0 roll, bit 1 pitch, bit 2 yaw
  //  3 ^ 1
  //    X
  //  2   0
  localparam logic [3:0][2:0] MIX_NEG = {3'b101, 3'b011, 3'b000, 3'b110};

  fc_pkg::loop_state_e state;
  logic [CNT_W-1:0]    gyro_cnt;
  logic                trigger;

  fc_pkg::axis_value_t setpoint [4];
  fc_pkg::axis_value_t rate     [3];
  fc_pkg::axis_value_t term     [3];
  fc_pkg::axis_value_t mix_sum  [4];

  function automatic fc_pkg::axis_value_t scale_rc(input fc_pkg::rc_value_t v);
    fc_pkg::axis_value_t wide;
    wide = $signed({21'd0, v});
    return ((wide * `FC_SP_SCALE_MUL) >>> `FC_SP_SCALE_SHIFT) - `FC_SP_OFFSET;
  endfunction

  function automatic fc_pkg::axis_value_t mix_value(input int motor);
    fc_pkg::axis_value_t sum;
    sum = setpoint[fc_pkg::THROTTLE];
    for (int a = 0; a < 3; a++) begin
      if (MIX_NEG[motor][a]) begin
        sum = sum - term[a];
      end else begin
        sum = sum + term[a];
      end
    end
    return sum + `FC_THROTTLE_OFFSET;
  endfunction

  function automatic fc_pkg::motor_cmd_t clamp_cmd(input fc_pkg::axis_value_t v);
    if (!arm || v < 0) begin
      return '0;
    end else if (v > `FC_MOTOR_MAX) begin
      return fc_pkg::motor_cmd_t'(`FC_MOTOR_MAX);
    end
    return v[10:0];
  endfunction

  // ====================
  // RC setpoints
  // ====================

  // Roll and pitch sticks are inverted against the gyro sense
  always_ff @(posedge clk) begin
    if (reset) begin
      setpoint[fc_pkg::THROTTLE] <= -32'sd500;
      setpoint[fc_pkg::ROLL]     <= '0;
      setpoint[fc_pkg::PITCH]    <= '0;
      setpoint[fc_pkg::YAW]      <= '0;
    end else if (rc_valid) begin
      setpoint[fc_pkg::THROTTLE] <= scale_rc(rc_throttle);
      setpoint[fc_pkg::ROLL]     <= -scale_rc(rc_roll);
      setpoint[fc_pkg::PITCH]    <= -scale_rc(rc_pitch);
      setpoint[fc_pkg::YAW]      <= scale_rc(rc_yaw);
    end
  end

  // ====================
  // Gyro decimation
  // ====================
  assign trigger = gyro_valid && (gyro_cnt == CNT_W'(`FC_GYRO_DIVIDE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      gyro_cnt <= '0;
    end else if (gyro_valid) begin
      gyro_cnt <= trigger ? '0 : gyro_cnt + 1'b1;
    end
  end

  // Rates only move when a run starts
  always_ff @(posedge clk) begin
    if (trigger && state == fc_pkg::LOOP_WAIT) begin
      rate[0] <= 32'(gyro_roll);
      rate[1] <= 32'(gyro_pitch);
      rate[2] <= 32'(gyro_yaw);
    end
  end

  // ====================
  // Loop sequence
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fc_pkg::LOOP_WAIT;
    end else begin
      case (state)
        fc_pkg::LOOP_WAIT:  if (trigger) state <= fc_pkg::LOOP_PID;
        fc_pkg::LOOP_PID:   state <= fc_pkg::LOOP_MIX;
        fc_pkg::LOOP_MIX:   state <= fc_pkg::LOOP_CLAMP;
        fc_pkg::LOOP_CLAMP: state <= fc_pkg::LOOP_APPLY;
        default:            state <= fc_pkg::LOOP_WAIT;
      endcase
    end
  end

  // Datapath registers, each stage loads in its own state
  always_ff @(posedge clk) begin
    if (state == fc_pkg::LOOP_PID) begin
      for (int a = 0; a < 3; a++) begin
        term[a] <= ((rate[a] - setpoint[a + 1]) * `FC_P_GAIN) >>> `FC_P_SHIFT;
      end
    end
    if (state == fc_pkg::LOOP_MIX) begin
      for (int m = 0; m < 4; m++) begin
        mix_sum[m] <= mix_value(m);
      end
    end
    if (state == fc_pkg::LOOP_CLAMP) begin
      for (int m = 0; m < 4; m++) begin
        cmd.cmd[m] <= clamp_cmd(mix_sum[m]);
      end
    end
  end

  assign cmd.cmd_valid = (state == fc_pkg::LOOP_APPLY);

endmodule

`default_nettype wire

/* verilog/fc_command_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_command_buffer (
  input  logic          clk,
  input  logic          reset,
  motor_cmd_if.buffer   cmd,
  dshot_frame_if.buffer frames
);

  // Telemetry request stays off
  function automatic fc_pkg::dshot_frame_t pack_frame(input fc_pkg::motor_cmd_t c);
    logic [11:0] upper;
    logic [3:0]  crc;
    upper = {c, 1'b0};
    crc   = upper[11:8] ^ upper[7:4] ^ upper[3:0];
    return {upper, crc};
  endfunction

  // ====================
  // Pending flag
  // ====================

  // A new set in the same cycle as a take keeps the flag up
  always_ff @(posedge clk) begin
    if (reset) begin
      frames.frame_valid <= 1'b0;
    end else if (cmd.cmd_valid) begin
      frames.frame_valid <= 1'b1;
    end else if (frames.frame_take) begin
      frames.frame_valid <= 1'b0;
    end
  end

  // Latest set wins, an untaken one is overwritten
  always_ff @(posedge clk) begin
    if (cmd.cmd_valid) begin
      for (int m = 0; m < 4; m++) begin
        frames.frames[m] <= pack_frame(cmd.cmd[m]);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dshot_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module dshot_tx (
  input  logic              clk,
  input  logic              reset,
  dshot_frame_if.serializer frames,
  output logic [3:0]        motor_out
);

  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_DATA = 2'd1,
    TX_GAP  = 2'd2
  } tx_state_e;

  tx_state_e                  state;
  logic [7:0]                 tick_cnt;
  logic [3:0]                 bit_cnt;
  fc_pkg::dshot_frame_t [3:0] shift_q;

  assign frames.frame_take = (state == TX_IDLE) && frames.frame_valid;

  // ====================
  // Shared bit timer
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (frames.frame_valid) state <= TX_DATA;
        end
        TX_DATA: begin
          if (tick_cnt == 8'(`FC_DSHOT_BIT_TICKS - 1)) begin
            tick_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            // Last bit done
            if (bit_cnt == 4'd15) state <= TX_GAP;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        TX_GAP: begin
          if (tick_cnt == 8'(`FC_DSHOT_GAP_TICKS - 1)) begin
            tick_cnt <= '0;
            state    <= TX_IDLE;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // MSB first on every lane
  always_ff @(posedge clk) begin
    if (frames.frame_take) begin
      shift_q <= frames.frames;
    end else if (state == TX_DATA && tick_cnt == 8'(`FC_DSHOT_BIT_TICKS - 1)) begin
      for (int l = 0; l < 4; l++) begin
        shift_q[l] <= {shift_q[l][14:0], 1'b0};
      end
    end
  end

  // Each bit opens high, the bit value sets the duty
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      motor_out[l] = (state == TX_DATA) &&
                     (tick_cnt < (shift_q[l][15] ? 8'(`FC_DSHOT_ONE_HIGH)
                                                 : 8'(`FC_DSHOT_ZERO_HIGH)));
    end
  end

endmodule

`default_nettype wire

/* verilog/flight_core.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_core (
  input  logic               clk,
  input  logic               reset,
  input  logic               arm,
  input  logic               rc_valid,
  input  fc_pkg::rc_value_t  rc_throttle,
  input  fc_pkg::rc_value_t  rc_roll,
  input  fc_pkg::rc_value_t  rc_pitch,
  input  fc_pkg::rc_value_t  rc_yaw,
  input  logic               gyro_valid,
  input  fc_pkg::gyro_rate_t gyro_roll,
  input  fc_pkg::gyro_rate_t gyro_pitch,
  input  fc_pkg::gyro_rate_t gyro_yaw,
  output logic               motor_1,
  output logic               motor_2,
  output logic               motor_3,
  output logic               motor_4
);

  logic [3:0] motor_out;

  motor_cmd_if   cmd_bus ();
  dshot_frame_if frame_bus ();

  // ====================
  // Rate loop, buffer, serializer
  // ====================
  fc_rate_loop i_rate_loop (
    .clk         (clk),
    .reset       (reset),
    .arm         (arm),
    .rc_valid    (rc_valid),
    .rc_throttle (rc_throttle),
    .rc_roll     (rc_roll),
    .rc_pitch    (rc_pitch),
    .rc_yaw      (rc_yaw),
    .gyro_valid  (gyro_valid),
    .gyro_roll   (gyro_roll),
    .gyro_pitch  (gyro_pitch),
    .gyro_yaw    (gyro_yaw),
    .cmd         (cmd_bus.producer)
  );

  fc_command_buffer i_command_buffer (
    .clk    (clk),
    .reset  (reset),
    .cmd    (cmd_bus.buffer),
    .frames (frame_bus.buffer)
  );

  dshot_tx i_dshot_tx (
    .clk       (clk),
    .reset     (reset),
    .frames    (frame_bus.serializer),
    .motor_out (motor_out)
  );

  // Motor pins in lane order
  assign motor_1 = motor_out[0];
  assign motor_2 = motor_out[1];
  assign motor_3 = motor_out[2];
  assign motor_4 = motor_out[3];

endmodule

`default_nettype wire

/* sim/flight_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module flight_core_assertions (
  input logic       clk,
  input logic       reset,
  input logic       gyro_valid,
  input logic       cmd_valid,
  input logic       frame_valid,
  input logic       frame_take,
  input logic [3:0] motor_out
);

  int failures = 0;

  // Pending frames wait for the serializer
  frame_held: assert property (@(posedge clk) disable iff (reset)
    frame_valid && !frame_take |=> frame_valid)
    else begin
      $error("frame_valid dropped before frame_take");
      failures++;
    end

  // Each loop run strobes once and four cycles after its gyro trigger
  cmd_single: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> $past(gyro_valid, 4) ##1 !cmd_valid)
    else begin
      $error("cmd_valid was not a single pulse four cycles after gyro_valid");
      failures++;
    end

  for (genvar l = 0; l < 4; l++) begin : g_lane
    high_time: assert property (@(posedge clk) disable iff (reset)
      motor_out[l] [*`FC_DSHOT_ONE_HIGH] |=> !motor_out[l])
      else begin
        $error("motor lane %0d high longer than a one bit", l);
        failures++;
      end
  end

endmodule

`default_nettype wire

/* sim/flight_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module flight_core_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int N_TESTS        = 6;
  localparam int STROBE_SPACING = 10;
  localparam int START_TIMEOUT  = 400;

  logic               clk;
  logic               reset;
  logic               arm;
  logic               rc_valid;
  fc_pkg::rc_value_t  rc_throttle;
  fc_pkg::rc_value_t  rc_roll;
  fc_pkg::rc_value_t  rc_pitch;
  fc_pkg::rc_value_t  rc_yaw;
  logic               gyro_valid;
  fc_pkg::gyro_rate_t gyro_roll;
  fc_pkg::gyro_rate_t gyro_pitch;
  fc_pkg::gyro_rate_t gyro_yaw;
  logic               motor_1;
  logic               motor_2;
  logic               motor_3;
  logic               motor_4;
  logic [3:0]         motor_bus;

  int                   errors;
  int                   assert_fails;
  int                   seed;
  // Model setpoints in throttle roll pitch yaw order
  int                   sp [4];
  fc_pkg::motor_cmd_t   exp_cmd [4];
  fc_pkg::dshot_frame_t got_frame [4];
  logic                 got_ok [4];

  assign motor_bus = {motor_4, motor_3, motor_2, motor_1};

  flight_core i_flight_core (
    .clk         (clk),
    .reset       (reset),
    .arm         (arm),
    .rc_valid    (rc_valid),
    .rc_throttle (rc_throttle),
    .rc_roll     (rc_roll),
    .rc_pitch    (rc_pitch),
    .rc_yaw      (rc_yaw),
    .gyro_valid  (gyro_valid),
    .gyro_roll   (gyro_roll),
    .gyro_pitch  (gyro_pitch),
    .gyro_yaw    (gyro_yaw),
    .motor_1     (motor_1),
    .motor_2     (motor_2),
    .motor_3     (motor_3),
    .motor_4     (motor_4)
  );

  bind flight_core flight_core_assertions i_assertions (
    .clk         (clk),
    .reset       (reset),
    .gyro_valid  (gyro_valid),
    .cmd_valid   (cmd_bus.cmd_valid),
    .frame_valid (frame_bus.frame_valid),
    .frame_take  (frame_bus.frame_take),
    .motor_out   (motor_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // Reference model
  // ====================
  function automatic int scale_rc(input int v);
    return (v * `FC_SP_SCALE_MUL) / (1 << `FC_SP_SCALE_SHIFT) - `FC_SP_OFFSET;
  endfunction

  // X quad mix table in roll pitch yaw bit order where a set bit subtracts
  function automatic int mix_sign(input int motor, input int axis);
    logic [2:0] neg;
    case (motor)
      0:       neg = 3'b011;
      1:       neg = 3'b000;
      2:       neg = 3'b110;
      default: neg = 3'b101;
    endcase
    return neg[2 - axis] ? -1 : 1;
  endfunction

  function automatic fc_pkg::motor_cmd_t model_motor(input int motor, input int gr,
                                                     input int gp, input int gy);
    int rates [3];
    int sum;
    rates[0] = gr;
    rates[1] = gp;
    rates[2] = gy;
    sum = sp[0] + `FC_THROTTLE_OFFSET;
    for (int a = 0; a < 3; a++) begin
      sum += mix_sign(motor, a) * (((rates[a] - sp[a + 1]) * `FC_P_GAIN) >>> `FC_P_SHIFT);
    end
    if (!arm || sum < 0) begin
      return '0;
    end
    if (sum > `FC_MOTOR_MAX) begin
      return fc_pkg::motor_cmd_t'(`FC_MOTOR_MAX);
    end
    return fc_pkg::motor_cmd_t'(sum);
  endfunction

  // Command with telemetry off and a nibble XOR checksum
  function automatic fc_pkg::dshot_frame_t frame_word(input fc_pkg::motor_cmd_t c);
    logic [11:0] head;
    head = {c, 1'b0};
    return {head, head[11:8] ^ head[7:4] ^ head[3:0]};
  endfunction

  // ====================
  // Stimulus
  // ====================
  task automatic set_sticks(input int thr, input int roll, input int pitch, input int yaw);
    @(posedge clk);
    #1;
    rc_throttle = fc_pkg::rc_value_t'(thr);
    rc_roll     = fc_pkg::rc_value_t'(roll);
    rc_pitch    = fc_pkg::rc_value_t'(pitch);
    rc_yaw      = fc_pkg::rc_value_t'(yaw);
    rc_valid    = 1'b1;
    @(posedge clk);
    #1;
    rc_valid = 1'b0;
    sp[0] = scale_rc(int'(rc_throttle));
    sp[1] = -scale_rc(int'(rc_roll));
    sp[2] = -scale_rc(int'(rc_pitch));
    sp[3] = scale_rc(int'(rc_yaw));
  endtask

  task automatic gyro_strobes(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (STROBE_SPACING - 1) @(posedge clk);
      @(posedge clk);
      #1;
      gyro_valid = 1'b1;
      @(posedge clk);
      #1;
      gyro_valid = 1'b0;
    end
  endtask

  task automatic set_rates(input int gr, input int gp, input int gy);
    @(posedge clk);
    #1;
    gyro_roll  = fc_pkg::gyro_rate_t'(gr);
    gyro_pitch = fc_pkg::gyro_rate_t'(gp);
    gyro_yaw   = fc_pkg::gyro_rate_t'(gy);
    for (int m = 0; m < 4; m++) begin
      exp_cmd[m] = model_motor(m, int'(gyro_roll), int'(gyro_pitch), int'(gyro_yaw));
    end
  endtask

  task automatic run_loop(input int gr, input int gp, input int gy);
    set_rates(gr, gp, gy);
    gyro_strobes(`FC_GYRO_DIVIDE);
  endtask

  task automatic set_arm(input logic level);
    @(posedge clk);
    #1;
    arm = level;
  endtask

  // ====================
  // DShot decoding
  // ====================
  task automatic decode_lane(input int lane, output fc_pkg::dshot_frame_t frame,
                             output logic ok);
    int waited;
    int high_cnt;
    frame  = '0;
    ok     = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!motor_bus[lane] && waited < START_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (motor_bus[lane]) else begin
      $display("motor_%0d: no DShot frame started within %0d cycles", lane + 1,
               START_TIMEOUT);
      errors++;
      ok = 1'b0;
    end
    if (ok) begin
      for (int b = 0; b < 16; b++) begin
        while (!motor_bus[lane]) begin
          @(negedge clk);
        end
        high_cnt = 0;
        while (motor_bus[lane]) begin
          high_cnt++;
          @(negedge clk);
        end
        frame = {frame[14:0], high_cnt > `FC_DSHOT_BIT_TICKS / 2};
      end
    end
  endtask

  task automatic check_frames(input string label);
    fork
      decode_lane(0, got_frame[0], got_ok[0]);
      decode_lane(1, got_frame[1], got_ok[1]);
      decode_lane(2, got_frame[2], got_ok[2]);
      decode_lane(3, got_frame[3], got_ok[3]);
    join
    for (int m = 0; m < 4; m++) begin
      if (got_ok[m]) begin
        assert (got_frame[m] == frame_word(exp_cmd[m])) else begin
          $display("** Error: motor_%0d frame (%s) expected %h got %h", m + 1, label,
                   frame_word(exp_cmd[m]), got_frame[m]);
          errors++;
        end
      end
    end
  endtask

  task automatic expect_quiet(input int cycles, input string label);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (motor_bus != 4'b0) begin
        seen = 1'b1;
      end
    end
    assert (!seen) else begin
      $display("%s: motor lines toggled when no frame was due", label);
      errors++;
    end
  endtask

  // Inside a frame a line is never low for a full bit period
  task automatic wait_gap();
    int low_cnt;
    low_cnt = 0;
    while (low_cnt < `FC_DSHOT_BIT_TICKS) begin
      @(negedge clk);
      low_cnt = motor_bus[0] ? 0 : low_cnt + 1;
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_disarm();
    assert (motor_bus == 4'b0) else begin
      $display("** Error: motor lines after reset expected %h got %h", 4'h0, motor_bus);
      errors++;
    end
    run_loop(0, 0, 0);
    check_frames("disarmed");
  endtask

  task automatic test_hover();
    set_arm(1'b1);
    set_sticks(992, 992, 992, 992);
    run_loop(0, 0, 0);
    check_frames("hover");
  endtask

  task automatic test_mix_signs();
    run_loop(120, 0, 0);
    check_frames("roll rate");
    run_loop(0, -80, 0);
    check_frames("pitch rate");
    run_loop(0, 0, 45);
    check_frames("yaw rate");
    set_sticks($random(seed), $random(seed), $random(seed), $random(seed));
    run_loop($random(seed) % 400, $random(seed) % 400, $random(seed) % 400);
    check_frames("random mix");
  endtask

  task automatic test_saturation();
    set_sticks(2047, 992, 992, 992);
    run_loop(3000, 0, 0);
    check_frames("full throttle");
    set_sticks(0, 992, 992, 992);
    run_loop(0, 0, -2500);
    check_frames("zero throttle");
  endtask

  task automatic test_decimation();
    set_sticks(992, 992, 992, 992);
    set_rates(-30, 60, 15);
    gyro_strobes(`FC_GYRO_DIVIDE - 1);
    expect_quiet(200, "decimation");
    gyro_strobes(1);
    check_frames("decimation");
  endtask

  // Runs two and three land while the first frame is on the wire
  task automatic test_latest_wins();
    run_loop(10, 20, 30);
    run_loop(-50, 0, 70);
    run_loop(200, -150, -60);
    wait_gap();
    check_frames("latest wins");
    expect_quiet(300, "latest wins");
  endtask

  initial begin
    #(N_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    arm         = 1'b0;
    rc_valid    = 1'b0;
    rc_throttle = '0;
    rc_roll     = '0;
    rc_pitch    = '0;
    rc_yaw      = '0;
    gyro_valid  = 1'b0;
    gyro_roll   = '0;
    gyro_pitch  = '0;
    gyro_yaw    = '0;
    errors      = 0;
    seed        = 59053;
    sp[0]       = -500;
    sp[1]       = 0;
    sp[2]       = 0;
    sp[3]       = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_disarm();
    test_hover();
    test_mix_signs();
    test_saturation();
    test_decimation();
    test_latest_wins();

    assert_fails = i_flight_core.i_assertions.failures;
    $display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flight_core.f */
+incdir+verilog
verilog/fc_pkg.sv
verilog/fc_ifs.sv
verilog/fc_rate_loop.sv
verilog/fc_command_buffer.sv
verilog/dshot_tx.sv
verilog/flight_core.sv
sim/flight_core_assertions.sv
sim/flight_core_tb.sv

/* Bender.yml */
package:
  name: flight_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fc_pkg.sv
      - verilog/fc_ifs.sv
      - verilog/fc_rate_loop.sv
      - verilog/fc_command_buffer.sv
      - verilog/dshot_tx.sv
      - verilog/flight_core.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/flight_core_assertions.sv
      - sim/flight_core_tb.sv
